// ==== ecc_pkg.sv ====
`default_nettype none

package ecc_pkg;

    localparam int DATA_WIDTH   = 62;
    localparam int PARITY_WIDTH = 8;
    localparam int ADDR_WIDTH   = 6;
    localparam int CNT_WIDTH    = 16;
    localparam int MEM_DEPTH    = 1 << ADDR_WIDTH;

    localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;

    // parity sits above data in the stored word.
    typedef struct packed {
        logic [PARITY_WIDTH-1:0] parity;
        logic [DATA_WIDTH-1:0]   data;
    } codeword_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_WIDTH-1:0] mask;
        logic                  sbit_err;
        logic                  dbit_err;
    } rd_resp_t;

    function automatic logic [PARITY_WIDTH-1:0] ecc_encode(input logic [DATA_WIDTH-1:0] d);
        logic [PARITY_WIDTH-1:0] p;
        p[0] = d[0]  ^ d[1]  ^ d[3]  ^ d[4]  ^ d[6]  ^ d[8]  ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32] ^ d[34]
             ^ d[36] ^ d[38] ^ d[40] ^ d[42] ^ d[44] ^ d[46] ^ d[48] ^ d[50] ^ d[52] ^ d[54]
             ^ d[56] ^ d[57] ^ d[59] ^ d[61];
        p[1] = d[0]  ^ d[2]  ^ d[3]  ^ d[5]  ^ d[6]  ^ d[9]  ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32] ^ d[35]
             ^ d[36] ^ d[39] ^ d[40] ^ d[43] ^ d[44] ^ d[47] ^ d[48] ^ d[51] ^ d[52] ^ d[55]
             ^ d[56] ^ d[58] ^ d[59];
        p[2] = d[1]  ^ d[2]  ^ d[3]  ^ d[7]  ^ d[8]  ^ d[9]  ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32] ^ d[37]
             ^ d[38] ^ d[39] ^ d[40] ^ d[45] ^ d[46] ^ d[47] ^ d[48] ^ d[53] ^ d[54] ^ d[55]
             ^ d[56] ^ d[60] ^ d[61];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[40:33]) ^ (^d[56:49]);
        p[4] = (^d[25:11]) ^ (^d[56:41]);
        p[5] = ^d[56:26];
        p[6] = ^d[61:57];
        p[7] = d[0]  ^ d[1]  ^ d[2]  ^ d[4]  ^ d[5]  ^ d[7]  ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32] ^ d[33]
             ^ d[36] ^ d[38] ^ d[39] ^ d[41] ^ d[44] ^ d[46] ^ d[47] ^ d[50] ^ d[51] ^ d[53]
             ^ d[56] ^ d[57] ^ d[58] ^ d[60];
        return p;
    endfunction

    // syndrome produced by a flip of one data bit.
    function automatic logic [PARITY_WIDTH-1:0] ecc_column(input int unsigned bit_idx);
        logic [DATA_WIDTH-1:0] one_hot;
        one_hot = '0;
        one_hot[bit_idx] = 1'b1;
        return ecc_encode(one_hot);
    endfunction

endpackage

`default_nettype wire

// ==== ecc_62_codec.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_62_codec (
    input  wire logic [ecc_pkg::DATA_WIDTH-1:0]   data_in,
    input  wire logic [ecc_pkg::PARITY_WIDTH-1:0] parity_in,
    input  wire logic                             bypass,
    output logic [ecc_pkg::DATA_WIDTH-1:0]        data_out,
    output logic [ecc_pkg::DATA_WIDTH-1:0]        mask,
    output logic                                  sbit_err,
    output logic                                  dbit_err
);

    logic [ecc_pkg::PARITY_WIDTH-1:0] syndrome;
    logic                             col_hit;    // syndrome names a data column.
    logic                             parity_hit; // single check bit flipped.
    logic                             sbit_raw;
    logic                             dbit_raw;

    assign syndrome = parity_in ^ ecc_pkg::ecc_encode(data_in);

    // columns are all distinct, so at most one mask bit is set.
    always_comb begin
        mask    = '0;
        col_hit = 1'b0;
        for (int i = 0; i < ecc_pkg::DATA_WIDTH; i++) begin
            if (syndrome == ecc_pkg::ecc_column(i)) begin
                mask[i] = 1'b1;
                col_hit = 1'b1;
            end
        end
    end

    assign parity_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    assign sbit_raw = col_hit | parity_hit;
    assign dbit_raw = (syndrome != '0) && !sbit_raw;

    // raw word and quiet flags in bypass.
    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : sbit_raw;
    assign dbit_err = bypass ? 1'b0 : dbit_raw;

    // data columns never collide with a single parity bit.
    always_comb begin
        if (!$isunknown({col_hit, parity_hit})) begin
            assert (!(col_hit && parity_hit))
                else $error("data column syndrome equals a single parity bit");
        end
    end

endmodule

`default_nettype wire

// ==== ecc_mem_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_store (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           wr_en,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  wire logic [ecc_pkg::DATA_WIDTH-1:0] wr_data,
    input  wire ecc_pkg::codeword_t             wr_inject,
    input  wire logic                           rd_en,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr,
    output logic                                rd_valid_s1,
    output logic [ecc_pkg::ADDR_WIDTH-1:0]      rd_addr_s1,
    output ecc_pkg::codeword_t                  rd_word
);

    ecc_pkg::codeword_t mem [ecc_pkg::MEM_DEPTH];
    ecc_pkg::codeword_t wr_word;

    // encode, then flip the injected bits.
    assign wr_word = {ecc_pkg::ecc_encode(wr_data), wr_data} ^ wr_inject;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // nonblocking read sees the old word on a collision.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word    <= mem[rd_addr];
            rd_addr_s1 <= rd_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid_s1 <= 1'b0;
        end else begin
            rd_valid_s1 <= rd_en;
        end
    end

    a_addr_known: assert property (@(posedge clk) disable iff (rst)
        (rd_en |-> !$isunknown(rd_addr)) and (wr_en |-> !$isunknown(wr_addr)))
        else $error("memory access with unknown address");

endmodule

`default_nettype wire

// ==== ecc_read_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_read_stage (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           bypass,
    input  wire logic                           rd_valid_s1,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr_s1,
    input  wire ecc_pkg::codeword_t             rd_word,
    output logic                                rd_valid,
    output logic [ecc_pkg::ADDR_WIDTH-1:0]      rd_addr_out,
    output ecc_pkg::rd_resp_t                   rd_resp
);

    ecc_pkg::rd_resp_t dec_resp;

    ecc_62_codec codec_i (
        .data_in   (rd_word.data),
        .parity_in (rd_word.parity),
        .bypass    (bypass),
        .data_out  (dec_resp.data),
        .mask      (dec_resp.mask),
        .sbit_err  (dec_resp.sbit_err),
        .dbit_err  (dec_resp.dbit_err)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid         <= 1'b0;
            rd_resp.sbit_err <= 1'b0;
            rd_resp.dbit_err <= 1'b0;
        end else begin
            rd_valid         <= rd_valid_s1;
            rd_resp.sbit_err <= rd_valid_s1 & dec_resp.sbit_err; // flags only with data.
            rd_resp.dbit_err <= rd_valid_s1 & dec_resp.dbit_err;
            if (rd_valid_s1) begin
                rd_resp.data <= dec_resp.data;
                rd_resp.mask <= dec_resp.mask;
                rd_addr_out  <= rd_addr_s1;
            end
        end
    end

    a_quiet_flags: assert property (@(posedge clk) disable iff (rst)
        !rd_valid |-> !(rd_resp.sbit_err || rd_resp.dbit_err))
        else $error("error flag raised without a valid response");

endmodule

`default_nettype wire

// ==== ecc_err_log.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_err_log (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           log_clr,
    input  wire logic                           rd_valid,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr_out,
    input  wire ecc_pkg::rd_resp_t              rd_resp,
    output logic [ecc_pkg::CNT_WIDTH-1:0]       corr_count,
    output logic [ecc_pkg::CNT_WIDTH-1:0]       uncorr_count,
    output logic                                first_err_valid,
    output logic [ecc_pkg::ADDR_WIDTH-1:0]      first_err_addr
);

    logic any_err;

    assign any_err = rd_valid && (rd_resp.sbit_err || rd_resp.dbit_err);

    // clear wins over a same-cycle update.
    always_ff @(posedge clk) begin
        if (rst || log_clr) begin
            corr_count      <= '0;
            uncorr_count    <= '0;
            first_err_valid <= 1'b0;
        end else begin
            if (rd_valid && rd_resp.sbit_err && corr_count != ecc_pkg::CNT_MAX) begin
                corr_count <= corr_count + 1'b1;
            end
            if (rd_valid && rd_resp.dbit_err && uncorr_count != ecc_pkg::CNT_MAX) begin
                uncorr_count <= uncorr_count + 1'b1;
            end
            if (any_err && !first_err_valid) begin
                first_err_valid <= 1'b1;
                first_err_addr  <= rd_addr_out; // held until the next clear.
            end
        end
    end

    a_corr_sat: assert property (@(posedge clk) disable iff (rst)
        (!log_clr && corr_count == ecc_pkg::CNT_MAX) |=> corr_count == ecc_pkg::CNT_MAX)
        else $error("corrected count wrapped");

    a_uncorr_sat: assert property (@(posedge clk) disable iff (rst)
        (!log_clr && uncorr_count == ecc_pkg::CNT_MAX) |=> uncorr_count == ecc_pkg::CNT_MAX)
        else $error("uncorrectable count wrapped");

endmodule

`default_nettype wire

// ==== ecc_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_top (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           wr_en,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0] wr_addr,
    input  wire logic [ecc_pkg::DATA_WIDTH-1:0] wr_data,
    input  wire ecc_pkg::codeword_t             wr_inject,
    input  wire logic                           rd_en,
    input  wire logic [ecc_pkg::ADDR_WIDTH-1:0] rd_addr,
    input  wire logic                           bypass,
    output logic                                rd_valid,
    output logic [ecc_pkg::ADDR_WIDTH-1:0]      rd_addr_out,
    output ecc_pkg::rd_resp_t                   rd_resp,
    input  wire logic                           log_clr,
    output logic [ecc_pkg::CNT_WIDTH-1:0]       corr_count,
    output logic [ecc_pkg::CNT_WIDTH-1:0]       uncorr_count,
    output logic                                first_err_valid,
    output logic [ecc_pkg::ADDR_WIDTH-1:0]      first_err_addr
);

    logic                             rd_valid_s1;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   rd_addr_s1;
    ecc_pkg::codeword_t               rd_word;

    ecc_mem_store store_i (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_inject   (wr_inject),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_valid_s1 (rd_valid_s1),
        .rd_addr_s1  (rd_addr_s1),
        .rd_word     (rd_word)
    );

    ecc_read_stage read_i (
        .clk         (clk),
        .rst         (rst),
        .bypass      (bypass),
        .rd_valid_s1 (rd_valid_s1),
        .rd_addr_s1  (rd_addr_s1),
        .rd_word     (rd_word),
        .rd_valid    (rd_valid),
        .rd_addr_out (rd_addr_out),
        .rd_resp     (rd_resp)
    );

    // log watches the same response that leaves the top.
    ecc_err_log log_i (
        .clk             (clk),
        .rst             (rst),
        .log_clr         (log_clr),
        .rd_valid        (rd_valid),
        .rd_addr_out     (rd_addr_out),
        .rd_resp         (rd_resp),
        .corr_count      (corr_count),
        .uncorr_count    (uncorr_count),
        .first_err_valid (first_err_valid),
        .first_err_addr  (first_err_addr)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 5;
    localparam int RST_CYCLES  = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0; // released just after the third edge.
    end

endmodule

`default_nettype wire

// ==== ecc_mem_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_tb;

    localparam int          CW_WIDTH       = ecc_pkg::DATA_WIDTH + ecc_pkg::PARITY_WIDTH;
    localparam logic [31:0] TIMEOUT_CYCLES = 32'd4000;

    typedef struct packed {
        logic [31:0]                    due;
        logic [ecc_pkg::ADDR_WIDTH-1:0] addr;
        logic                           byp;
        ecc_pkg::rd_resp_t              resp;
    } exp_t;

    logic                             clk;
    logic                             rst;
    logic                             wr_en;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   wr_addr;
    logic [ecc_pkg::DATA_WIDTH-1:0]   wr_data;
    ecc_pkg::codeword_t               wr_inject;
    logic                             rd_en;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   rd_addr;
    logic                             bypass;
    logic                             rd_valid;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   rd_addr_out;
    ecc_pkg::rd_resp_t                rd_resp;
    logic                             log_clr;
    logic [ecc_pkg::CNT_WIDTH-1:0]    corr_count;
    logic [ecc_pkg::CNT_WIDTH-1:0]    uncorr_count;
    logic                             first_err_valid;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   first_err_addr;

    logic [ecc_pkg::DATA_WIDTH-1:0]   model_data [ecc_pkg::MEM_DEPTH];
    ecc_pkg::codeword_t               model_inj [ecc_pkg::MEM_DEPTH];
    exp_t                             exp_q [$];
    logic [31:0]                      cycle = '0;
    logic [31:0]                      lfsr = 32'h27e8_63a9;
    logic [ecc_pkg::CNT_WIDTH-1:0]    exp_corr = '0;
    logic [ecc_pkg::CNT_WIDTH-1:0]    exp_uncorr = '0;
    logic                             exp_first_valid = 1'b0;
    logic [ecc_pkg::ADDR_WIDTH-1:0]   exp_first_addr = '0;

    tb_clk_gen clk_gen_i (.clk(clk), .rst(rst));

    ecc_mem_top ecc_mem_top_i (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .wr_inject(wr_inject), .rd_en(rd_en), .rd_addr(rd_addr), .bypass(bypass),
        .rd_valid(rd_valid), .rd_addr_out(rd_addr_out), .rd_resp(rd_resp),
        .log_clr(log_clr), .corr_count(corr_count), .uncorr_count(uncorr_count),
        .first_err_valid(first_err_valid), .first_err_addr(first_err_addr)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_eq(
        input string       name,
        input logic [63:0] exp_v,
        input logic [63:0] act_v
    );
        assert (act_v === exp_v)
            else fail_run($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
    endtask

    // taps 32, 22, 2, 1.
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], next_bit()};
        end
        return r;
    endfunction

    // parity bits sit above the data bits in the codeword.
    function automatic logic [ecc_pkg::PARITY_WIDTH-1:0] col_syndrome(input int idx);
        logic [ecc_pkg::DATA_WIDTH-1:0]   one_hot;
        logic [ecc_pkg::PARITY_WIDTH-1:0] syn;
        syn = '0;
        if (idx < ecc_pkg::DATA_WIDTH) begin
            one_hot = '0;
            one_hot[idx] = 1'b1;
            syn = ecc_pkg::ecc_encode(one_hot);
        end else begin
            syn[idx - ecc_pkg::DATA_WIDTH] = 1'b1;
        end
        return syn;
    endfunction

    function automatic ecc_pkg::codeword_t bit_inj(input int idx);
        logic [CW_WIDTH-1:0] v;
        v = '0;
        v[idx] = 1'b1;
        return v;
    endfunction

    function automatic exp_t predict(input logic [ecc_pkg::ADDR_WIDTH-1:0] a, input logic byp);
        exp_t                             e;
        logic [CW_WIDTH-1:0]              inj;
        logic [ecc_pkg::PARITY_WIDTH-1:0] syn;
        logic [ecc_pkg::DATA_WIDTH-1:0]   raw;
        inj = model_inj[a];
        raw = model_data[a] ^ model_inj[a].data;
        syn = '0;
        for (int i = 0; i < CW_WIDTH; i++) begin
            if (inj[i]) syn = syn ^ col_syndrome(i); // code is linear.
        end
        e.due = cycle + 32'd2;
        e.addr = a;
        e.byp = byp;
        e.resp.mask = '0;
        e.resp.sbit_err = 1'b0;
        e.resp.dbit_err = 1'b0;
        for (int j = 0; j < ecc_pkg::DATA_WIDTH; j++) begin
            if (syn == col_syndrome(j)) begin
                e.resp.mask[j] = 1'b1;
                e.resp.sbit_err = 1'b1;
            end
        end
        if (syn != '0 && !e.resp.sbit_err) begin
            e.resp.sbit_err = $onehot(syn);
            e.resp.dbit_err = !$onehot(syn);
        end
        e.resp.data = byp ? raw : (raw ^ e.resp.mask);
        if (byp) begin
            e.resp.sbit_err = 1'b0;
            e.resp.dbit_err = 1'b0;
        end
        return e;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        wr_en = 1'b0;
        rd_en = 1'b0;
        wr_inject = '0;
    endtask

    task automatic write_set(
        input logic [ecc_pkg::ADDR_WIDTH-1:0] a,
        input logic [ecc_pkg::DATA_WIDTH-1:0] d,
        input ecc_pkg::codeword_t             inj
    );
        wr_en = 1'b1;
        wr_addr = a;
        wr_data = d;
        wr_inject = inj;
        model_data[a] = d;
        model_inj[a] = inj;
    endtask

    task automatic read_set(input logic [ecc_pkg::ADDR_WIDTH-1:0] a);
        rd_en = 1'b1;
        rd_addr = a;
        exp_q.push_back(predict(a, bypass));
    endtask

    task automatic write_word(
        input logic [ecc_pkg::ADDR_WIDTH-1:0] a,
        input logic [ecc_pkg::DATA_WIDTH-1:0] d,
        input ecc_pkg::codeword_t             inj
    );
        write_set(a, d, inj);
        step();
        idle();
    endtask

    task automatic read_word(input logic [ecc_pkg::ADDR_WIDTH-1:0] a);
        read_set(a);
        step();
        idle();
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            step();
        end
    endtask

    task automatic check_log();
        expect_eq("corr_count", 64'(exp_corr), 64'(corr_count));
        expect_eq("uncorr_count", 64'(exp_uncorr), 64'(uncorr_count));
        expect_eq("first_err_valid", 64'(exp_first_valid), 64'(first_err_valid));
        if (exp_first_valid) expect_eq("first_err_addr", 64'(exp_first_addr), 64'(first_err_addr));
    endtask

    task automatic round_trip();
        for (int a = 0; a < ecc_pkg::MEM_DEPTH; a++) begin
            write_set(6'(a), 62'(rand_bits(62)), '0);
            step();
        end
        idle();
        for (int a = 0; a < ecc_pkg::MEM_DEPTH; a++) begin
            read_set(6'(a)); // back-to-back reads.
            step();
        end
        idle();
        drain();
        check_log();
    endtask

    task automatic correct_single_bits();
        for (int i = 0; i < CW_WIDTH; i++) begin
            write_word(6'(i), 62'(rand_bits(62)), bit_inj(i));
            read_word(6'(i));
        end
        drain();
    endtask

    task automatic detect_double_bits();
        int                  i;
        int                  j;
        logic [CW_WIDTH-1:0] pair;
        for (int n = 0; n < 100; n++) begin
            i = int'(rand_bits(7) % 64'd70);
            j = (i + 1 + int'(rand_bits(7) % 64'd69)) % CW_WIDTH;
            pair = bit_inj(i) | bit_inj(j);
            write_word(6'(n), 62'(rand_bits(62)), pair);
            read_word(6'(n));
        end
        drain();
    endtask

    task automatic read_bypassed();
        bypass = 1'b1;
        for (int n = 0; n < 8; n++) begin
            write_word(6'(40 + n), 62'(rand_bits(62)), bit_inj(n * 9) | bit_inj(n * 4));
            read_word(6'(40 + n));
        end
        drain();
        bypass = 1'b0;
    endtask

    task automatic clear_log();
        log_clr = 1'b1;
        step();
        log_clr = 1'b0;
        exp_corr = '0;
        exp_uncorr = '0;
        exp_first_valid = 1'b0;
        check_log();
        write_word(6'd5, 62'(rand_bits(62)), '0);
        read_set(6'd5); // same edge as the write, old word expected.
        write_set(6'd5, 62'(rand_bits(62)), '0);
        step();
        idle();
        read_word(6'd5);
        drain();
        check_log();
    endtask

    // timeout.
    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
        if (cycle >= TIMEOUT_CYCLES) fail_run("timeout: test did not finish within the cycle limit");
    end

    always @(negedge clk) begin : monitor
        exp_t e;
        if (!rst && rd_valid === 1'b1) begin
            assert (exp_q.size() != 0) else fail_run("rd_valid high with no read outstanding");
            e = exp_q.pop_front();
            expect_eq("rd_valid latency", 64'(e.due), 64'(cycle));
            expect_eq("rd_addr_out", 64'(e.addr), 64'(rd_addr_out));
            expect_eq("rd_resp.data", 64'(e.resp.data), 64'(rd_resp.data));
            if (!e.byp) expect_eq("rd_resp.mask", 64'(e.resp.mask), 64'(rd_resp.mask));
            expect_eq("rd_resp.sbit_err", 64'(e.resp.sbit_err), 64'(rd_resp.sbit_err));
            expect_eq("rd_resp.dbit_err", 64'(e.resp.dbit_err), 64'(rd_resp.dbit_err));
            if (e.resp.sbit_err && exp_corr != '1) exp_corr = exp_corr + 16'd1;
            if (e.resp.dbit_err && exp_uncorr != '1) exp_uncorr = exp_uncorr + 16'd1;
            if ((e.resp.sbit_err || e.resp.dbit_err) && !exp_first_valid) begin
                exp_first_valid = 1'b1;
                exp_first_addr = e.addr;
            end
        end else if (!rst && exp_q.size() != 0) begin
            assert (exp_q[0].due > cycle) else fail_run("rd_valid missing two cycles after rd_en");
        end
    end

    initial begin
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_inject = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        bypass = 1'b0;
        log_clr = 1'b0;
        wait (rst == 1'b0);
        step();
        round_trip();
        correct_single_bits();
        detect_double_bits();
        check_log();
        read_bypassed();
        clear_log();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
ecc_pkg.sv
ecc_62_codec.sv
ecc_mem_store.sv
ecc_read_stage.sv
ecc_err_log.sv
ecc_mem_top.sv
tb_clk_gen.sv
ecc_mem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ecc_mem_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
